/* hw/cpu_macros.svh */
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// data and address width.
`define CPU_WORD_W      16

// register file shape.
`define CPU_NUM_REGS    4
`define CPU_REG_IDX_W   2
`define CPU_LINK_REG    2

// instruction field widths.
`define CPU_OPCODE_W    4
`define CPU_FUNCT_W     6
`define CPU_IMM_W       8
`define CPU_TGT_W       12

`endif

/* hw/isa_pkg.sv */
`include "cpu_macros.svh"

package isa_pkg;

    // major opcodes, bits 15:12.
    typedef enum logic [`CPU_OPCODE_W-1:0] {
        OP_BNE   = 4'd0,
        OP_BEQ   = 4'd1,
        OP_BGZ   = 4'd2,
        OP_BLZ   = 4'd3,
        OP_ADI   = 4'd4,
        OP_ORI   = 4'd5,
        OP_LHI   = 4'd6,
        OP_LWD   = 4'd7,
        OP_SWD   = 4'd8,
        OP_JMP   = 4'd9,
        OP_JAL   = 4'd10,
        OP_RTYPE = 4'd15
    } opcode_e;

    // funct codes under OP_RTYPE.
    typedef enum logic [`CPU_FUNCT_W-1:0] {
        FN_ADD = 6'd0,
        FN_SUB = 6'd1,
        FN_AND = 6'd2,
        FN_ORR = 6'd3,
        FN_NOT = 6'd4,
        FN_TCP = 6'd5,
        FN_SHL = 6'd6,
        FN_SHR = 6'd7,
        FN_JPR = 6'd25,
        FN_JRL = 6'd26,
        FN_WWD = 6'd28,
        FN_HLT = 6'd29
    } funct_e;

    typedef struct packed {
        opcode_e                   opcode;
        logic [`CPU_REG_IDX_W-1:0] rs;
        logic [`CPU_REG_IDX_W-1:0] rt;
        logic [`CPU_REG_IDX_W-1:0] rd;
        logic [`CPU_FUNCT_W-1:0]   funct;
    } instr_t;

    ////////////////////
    // field helpers
    ////////////////////

    // immediate overlaps rd and funct.
    function automatic logic [`CPU_IMM_W-1:0] imm_field(instr_t i);
        return {i.rd, i.funct};
    endfunction

    function automatic logic [`CPU_TGT_W-1:0] tgt_field(instr_t i);
        return {i.rs, i.rt, i.rd, i.funct};
    endfunction

    function automatic logic [`CPU_WORD_W-1:0] imm_sext(instr_t i);
        logic [`CPU_IMM_W-1:0] imm;
        imm = imm_field(i);
        return {{(`CPU_WORD_W-`CPU_IMM_W){imm[`CPU_IMM_W-1]}}, imm};
    endfunction

    function automatic logic [`CPU_WORD_W-1:0] imm_zext(instr_t i);
        return {{(`CPU_WORD_W-`CPU_IMM_W){1'b0}}, imm_field(i)};
    endfunction

endpackage

/* hw/ctrl_pkg.sv */
package ctrl_pkg;

    typedef enum logic [3:0] {
        ALU_ADD = 4'd0,
        ALU_SUB = 4'd1,
        ALU_AND = 4'd2,
        ALU_ORR = 4'd3,
        ALU_NOT = 4'd4,
        ALU_TCP = 4'd5,
        ALU_SHL = 4'd6,
        ALU_SHR = 4'd7,
        ALU_LHI = 4'd8,
        ALU_IDN = 4'd9,
        ALU_ZRO = 4'd10
    } alu_func_e;

    typedef enum logic [2:0] {
        BR_NONE = 3'd0,
        BR_NE   = 3'd1,
        BR_EQ   = 3'd2,
        BR_GZ   = 3'd3,
        BR_LZ   = 3'd4
    } branch_e;

    // TGT uses the 12-bit target field, REG uses rs.
    typedef enum logic [1:0] {
        JMP_NONE = 2'd0,
        JMP_TGT  = 2'd1,
        JMP_REG  = 2'd2
    } jump_e;

    typedef enum logic [1:0] {
        DEST_RD = 2'd0,
        DEST_RT = 2'd1,
        DEST_R2 = 2'd2
    } dest_e;

    typedef enum logic [1:0] {
        IMM_NONE = 2'd0,
        IMM_SEXT = 2'd1,
        IMM_ZEXT = 2'd2
    } imm_e;

    typedef enum logic [1:0] {
        ST_START = 2'd0,
        ST_RUN   = 2'd1,
        ST_HALT  = 2'd2
    } cpu_state_e;

    // write, strobe and advance bits only ever set in RUN.
    typedef struct packed {
        alu_func_e alu_func;
        imm_e      imm_sel;
        logic      reg_write;
        dest_e     dest;
        logic      mem_read;
        logic      mem_write;
        logic      pc_to_reg;
        branch_e   branch;
        jump_e     jump;
        logic      wwd;
        logic      advance;
    } ctrl_word_t;

endpackage

/* hw/control_unit.sv */
module control_unit (
    input  logic                 clk,
    input  logic                 arst_n,
    input  isa_pkg::instr_t      instr,
    output ctrl_pkg::ctrl_word_t ctrl,
    output logic                 halted
);

    ctrl_pkg::cpu_state_e state;
    ctrl_pkg::branch_e    br;
    ctrl_pkg::jump_e      jmp;
    ctrl_pkg::alu_func_e  func;
    ctrl_pkg::imm_e       imm;
    logic                 run;
    logic is_rtype, is_itype, is_load, is_store, is_link, is_wwd, is_halt;

    ////////////////////
    // classify
    ////////////////////

    always_comb begin
        is_rtype = 1'b0;
        is_itype = 1'b0;
        is_load  = 1'b0;
        is_store = 1'b0;
        is_link  = 1'b0;
        is_wwd   = 1'b0;
        is_halt  = 1'b0;
        br       = ctrl_pkg::BR_NONE;
        jmp      = ctrl_pkg::JMP_NONE;
        func     = ctrl_pkg::ALU_ZRO;
        imm      = ctrl_pkg::IMM_NONE;
        case (instr.opcode)
            isa_pkg::OP_ADI: begin
                is_itype = 1'b1;
                func     = ctrl_pkg::ALU_ADD;
                imm      = ctrl_pkg::IMM_SEXT;
            end
            isa_pkg::OP_ORI: begin
                is_itype = 1'b1;
                func     = ctrl_pkg::ALU_ORR;
                imm      = ctrl_pkg::IMM_ZEXT;
            end
            isa_pkg::OP_LHI: begin
                is_itype = 1'b1;
                func     = ctrl_pkg::ALU_LHI;
                imm      = ctrl_pkg::IMM_ZEXT;
            end
            // loads and stores address rs plus sext imm.
            isa_pkg::OP_LWD: begin
                is_load = 1'b1;
                func    = ctrl_pkg::ALU_ADD;
                imm     = ctrl_pkg::IMM_SEXT;
            end
            isa_pkg::OP_SWD: begin
                is_store = 1'b1;
                func     = ctrl_pkg::ALU_ADD;
                imm      = ctrl_pkg::IMM_SEXT;
            end
            isa_pkg::OP_BNE: br = ctrl_pkg::BR_NE;
            isa_pkg::OP_BEQ: br = ctrl_pkg::BR_EQ;
            isa_pkg::OP_BGZ: br = ctrl_pkg::BR_GZ;
            isa_pkg::OP_BLZ: br = ctrl_pkg::BR_LZ;
            isa_pkg::OP_JMP: jmp = ctrl_pkg::JMP_TGT;
            isa_pkg::OP_JAL: begin
                jmp     = ctrl_pkg::JMP_TGT;
                is_link = 1'b1;
            end
            isa_pkg::OP_RTYPE: begin
                is_rtype = 1'b1;
                case (instr.funct)
                    isa_pkg::FN_ADD: func = ctrl_pkg::ALU_ADD;
                    isa_pkg::FN_SUB: func = ctrl_pkg::ALU_SUB;
                    isa_pkg::FN_AND: func = ctrl_pkg::ALU_AND;
                    isa_pkg::FN_ORR: func = ctrl_pkg::ALU_ORR;
                    isa_pkg::FN_NOT: func = ctrl_pkg::ALU_NOT;
                    isa_pkg::FN_TCP: func = ctrl_pkg::ALU_TCP;
                    isa_pkg::FN_SHL: func = ctrl_pkg::ALU_SHL;
                    isa_pkg::FN_SHR: func = ctrl_pkg::ALU_SHR;
                    default: begin
                        // not an alu op, so no rd write.
                        is_rtype = 1'b0;
                        case (instr.funct)
                            isa_pkg::FN_JPR: jmp = ctrl_pkg::JMP_REG;
                            isa_pkg::FN_JRL: begin
                                jmp     = ctrl_pkg::JMP_REG;
                                is_link = 1'b1;
                            end
                            isa_pkg::FN_WWD: begin
                                is_wwd = 1'b1;
                                func   = ctrl_pkg::ALU_IDN;
                            end
                            isa_pkg::FN_HLT: is_halt = 1'b1;
                            default: is_halt = 1'b0;
                        endcase
                    end
                endcase
            end
            default: func = ctrl_pkg::ALU_ZRO;
        endcase
    end

    ////////////////////
    // state
    ////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= ctrl_pkg::ST_START;
        end else begin
            case (state)
                ctrl_pkg::ST_START: state <= ctrl_pkg::ST_RUN;
                ctrl_pkg::ST_RUN: begin
                    if (is_halt) begin
                        state <= ctrl_pkg::ST_HALT;
                    end
                end
                ctrl_pkg::ST_HALT: state <= ctrl_pkg::ST_HALT;
                default: state <= ctrl_pkg::ST_START;
            endcase
        end
    end

    assign run    = (state == ctrl_pkg::ST_RUN);
    assign halted = (state == ctrl_pkg::ST_HALT);

    always_comb begin
        ctrl.alu_func  = func;
        ctrl.imm_sel   = imm;
        ctrl.reg_write = run & (is_rtype | is_itype | is_load | is_link);
        if (is_link) begin
            ctrl.dest = ctrl_pkg::DEST_R2;
        end else if (is_itype | is_load) begin
            ctrl.dest = ctrl_pkg::DEST_RT;
        end else begin
            ctrl.dest = ctrl_pkg::DEST_RD;
        end
        ctrl.mem_read  = is_load;
        ctrl.mem_write = run & is_store;
        ctrl.pc_to_reg = is_link;
        ctrl.branch    = br;
        ctrl.jump      = jmp;
        ctrl.wwd       = run & is_wwd;
        // pc holds on HLT.
        ctrl.advance   = run & ~is_halt;
    end

endmodule

/* hw/alu.sv */
`include "cpu_macros.svh"

module alu (
    input  ctrl_pkg::ctrl_word_t   ctrl,
    input  isa_pkg::instr_t        instr,
    input  logic [`CPU_WORD_W-1:0] rs_data,
    input  logic [`CPU_WORD_W-1:0] rt_data,
    output logic [`CPU_WORD_W-1:0] result
);

    logic [`CPU_WORD_W-1:0] op_b;

    // second operand.
    always_comb begin
        case (ctrl.imm_sel)
            ctrl_pkg::IMM_SEXT: op_b = isa_pkg::imm_sext(instr);
            ctrl_pkg::IMM_ZEXT: op_b = isa_pkg::imm_zext(instr);
            default:            op_b = rt_data;
        endcase
    end

    always_comb begin
        case (ctrl.alu_func)
            ctrl_pkg::ALU_ADD: result = rs_data + op_b;
            ctrl_pkg::ALU_SUB: result = rs_data - op_b;
            ctrl_pkg::ALU_AND: result = rs_data & op_b;
            ctrl_pkg::ALU_ORR: result = rs_data | op_b;
            ctrl_pkg::ALU_NOT: result = ~rs_data;
            ctrl_pkg::ALU_TCP: result = ~rs_data + 1'b1;
            ctrl_pkg::ALU_SHL: result = {rs_data[`CPU_WORD_W-2:0], 1'b0};
            // arithmetic, keeps the sign bit.
            ctrl_pkg::ALU_SHR: begin
                result = {rs_data[`CPU_WORD_W-1], rs_data[`CPU_WORD_W-1:1]};
            end
            ctrl_pkg::ALU_LHI: begin
                result = {op_b[`CPU_IMM_W-1:0], {(`CPU_WORD_W-`CPU_IMM_W){1'b0}}};
            end
            ctrl_pkg::ALU_IDN: result = rs_data;
            default:           result = '0;
        endcase
    end

endmodule

/* hw/register_file.sv */
`include "cpu_macros.svh"

module register_file (
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic [`CPU_REG_IDX_W-1:0] rs_idx,
    input  logic [`CPU_REG_IDX_W-1:0] rt_idx,
    output logic [`CPU_WORD_W-1:0]    rs_data,
    output logic [`CPU_WORD_W-1:0]    rt_data,
    input  logic                      wr_en,
    input  logic [`CPU_REG_IDX_W-1:0] wr_idx,
    input  logic [`CPU_WORD_W-1:0]    wr_data
);

    logic [`CPU_WORD_W-1:0] regs [`CPU_NUM_REGS];

    // reads see the old value until the edge.
    assign rs_data = regs[rs_idx];
    assign rt_data = regs[rt_idx];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `CPU_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wr_idx] <= wr_data;
        end
    end

endmodule

/* hw/pc_unit.sv */
`include "cpu_macros.svh"

module pc_unit (
    input  logic                   clk,
    input  logic                   arst_n,
    input  ctrl_pkg::ctrl_word_t   ctrl,
    input  isa_pkg::instr_t        instr,
    input  logic [`CPU_WORD_W-1:0] rs_data,
    input  logic [`CPU_WORD_W-1:0] rt_data,
    output logic [`CPU_WORD_W-1:0] pc,
    output logic [`CPU_WORD_W-1:0] pc_plus1
);

    logic                   taken;
    logic [`CPU_WORD_W-1:0] pc_next;

    assign pc_plus1 = pc + 1'b1;

    ////////////////////
    // branch compare
    ////////////////////

    always_comb begin
        case (ctrl.branch)
            ctrl_pkg::BR_NE: taken = (rs_data != rt_data);
            ctrl_pkg::BR_EQ: taken = (rs_data == rt_data);
            ctrl_pkg::BR_GZ: taken = ($signed(rs_data) > 0);
            ctrl_pkg::BR_LZ: taken = ($signed(rs_data) < 0);
            default:         taken = 1'b0;
        endcase
    end

    // jumps first, branches relative to pc+1.
    always_comb begin
        case (ctrl.jump)
            ctrl_pkg::JMP_TGT: begin
                pc_next = {pc[`CPU_WORD_W-1:`CPU_TGT_W], isa_pkg::tgt_field(instr)};
            end
            ctrl_pkg::JMP_REG: pc_next = rs_data;
            default: begin
                pc_next = taken ? pc_plus1 + isa_pkg::imm_sext(instr) : pc_plus1;
            end
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc <= '0;
        end else if (ctrl.advance) begin
            pc <= pc_next;
        end
    end

endmodule

/* hw/cpu_core.sv */
`include "cpu_macros.svh"

module cpu_core (
    input  logic                   clk,
    input  logic                   arst_n,
    output logic [`CPU_WORD_W-1:0] inst_addr,
    input  logic [`CPU_WORD_W-1:0] inst_data,
    output logic [`CPU_WORD_W-1:0] d_addr,
    output logic [`CPU_WORD_W-1:0] d_wdata,
    output logic                   d_write,
    input  logic [`CPU_WORD_W-1:0] d_rdata,
    output logic                   wwd_valid,
    output logic [`CPU_WORD_W-1:0] wwd_data,
    output logic                   halted
);

    isa_pkg::instr_t           instr;
    ctrl_pkg::ctrl_word_t      ctrl;
    logic [`CPU_WORD_W-1:0]    rs_data;
    logic [`CPU_WORD_W-1:0]    rt_data;
    logic [`CPU_WORD_W-1:0]    alu_result;
    logic [`CPU_WORD_W-1:0]    pc_plus1;
    logic [`CPU_WORD_W-1:0]    wb_data;
    logic [`CPU_REG_IDX_W-1:0] wb_idx;

    assign instr = inst_data;

    control_unit i_control_unit (
        .clk    (clk),
        .arst_n (arst_n),
        .instr  (instr),
        .ctrl   (ctrl),
        .halted (halted)
    );

    register_file i_register_file (
        .clk     (clk),
        .arst_n  (arst_n),
        .rs_idx  (instr.rs),
        .rt_idx  (instr.rt),
        .rs_data (rs_data),
        .rt_data (rt_data),
        .wr_en   (ctrl.reg_write),
        .wr_idx  (wb_idx),
        .wr_data (wb_data)
    );

    alu i_alu (
        .ctrl    (ctrl),
        .instr   (instr),
        .rs_data (rs_data),
        .rt_data (rt_data),
        .result  (alu_result)
    );

    pc_unit i_pc_unit (
        .clk      (clk),
        .arst_n   (arst_n),
        .ctrl     (ctrl),
        .instr    (instr),
        .rs_data  (rs_data),
        .rt_data  (rt_data),
        .pc       (inst_addr),
        .pc_plus1 (pc_plus1)
    );

    ////////////////////
    // write-back
    ////////////////////

    // link beats load beats alu.
    assign wb_data = ctrl.pc_to_reg ? pc_plus1 :
                     ctrl.mem_read  ? d_rdata  : alu_result;

    always_comb begin
        case (ctrl.dest)
            ctrl_pkg::DEST_RT: wb_idx = instr.rt;
            ctrl_pkg::DEST_R2: wb_idx = `CPU_REG_IDX_W'(`CPU_LINK_REG);
            default:           wb_idx = instr.rd;
        endcase
    end

    // data and wwd ports.
    assign d_addr    = alu_result;
    assign d_wdata   = rt_data;
    assign d_write   = ctrl.mem_write;
    assign wwd_valid = ctrl.wwd;
    assign wwd_data  = alu_result;

endmodule

/* dv/tb_program.svh */
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

// instruction encoders.
function automatic logic [15:0] enc_r(isa_pkg::funct_e fn, int rs, int rt, int rd);
    return {isa_pkg::OP_RTYPE, 2'(rs), 2'(rt), 2'(rd), fn};
endfunction

function automatic logic [15:0] enc_i(isa_pkg::opcode_e op, int rs, int rt, int imm);
    return {op, 2'(rs), 2'(rt), 8'(imm)};
endfunction

function automatic logic [15:0] enc_j(isa_pkg::opcode_e op, int tgt);
    return {op, 12'(tgt)};
endfunction

task automatic put(logic [15:0] word);
    imem[prog_len] = word;
    prog_len++;
endtask

task automatic expect_wwd(logic [15:0] value);
    exp_wwd[n_wwd] = value;
    n_wwd++;
endtask

task automatic build_program();
    logic [15:0] sum;
    int q;
    // r0 still at its reset value.
    put(enc_r(isa_pkg::FN_WWD, 0, 0, 0));
    expect_wwd(16'h0000);
    // alu and immediate forms.
    put(enc_i(isa_pkg::OP_ADI, 0, 0, 8'h35));
    put(enc_r(isa_pkg::FN_WWD, 0, 0, 0));
    expect_wwd(16'h0035);
    put(enc_i(isa_pkg::OP_ADI, 1, 1, 8'hF0));
    put(enc_r(isa_pkg::FN_WWD, 1, 0, 0));
    expect_wwd(16'hFFF0);
    put(enc_i(isa_pkg::OP_LHI, 0, 1, 8'hA5));
    put(enc_r(isa_pkg::FN_WWD, 1, 0, 0));
    expect_wwd(16'hA500);
    put(enc_i(isa_pkg::OP_ORI, 1, 1, 8'hC3));
    put(enc_r(isa_pkg::FN_WWD, 1, 0, 0));
    expect_wwd(16'hA5C3);
    put(enc_r(isa_pkg::FN_ADD, 0, 1, 2));
    put(enc_r(isa_pkg::FN_WWD, 2, 0, 0));
    expect_wwd(16'h0035 + 16'hA5C3);
    put(enc_r(isa_pkg::FN_SUB, 1, 0, 3));
    put(enc_r(isa_pkg::FN_WWD, 3, 0, 0));
    expect_wwd(16'hA5C3 - 16'h0035);
    put(enc_r(isa_pkg::FN_AND, 1, 3, 2));
    put(enc_r(isa_pkg::FN_WWD, 2, 0, 0));
    expect_wwd(16'hA5C3 & (16'hA5C3 - 16'h0035));
    put(enc_r(isa_pkg::FN_ORR, 0, 1, 2));
    put(enc_r(isa_pkg::FN_WWD, 2, 0, 0));
    expect_wwd(16'h0035 | 16'hA5C3);
    put(enc_r(isa_pkg::FN_NOT, 1, 0, 2));
    put(enc_r(isa_pkg::FN_WWD, 2, 0, 0));
    expect_wwd(~16'hA5C3);
    put(enc_r(isa_pkg::FN_TCP, 0, 0, 2));
    put(enc_r(isa_pkg::FN_WWD, 2, 0, 0));
    expect_wwd(16'h0000 - 16'h0035);
    put(enc_r(isa_pkg::FN_SHL, 1, 0, 2));
    put(enc_r(isa_pkg::FN_WWD, 2, 0, 0));
    expect_wwd(16'h4B86);
    put(enc_r(isa_pkg::FN_SHR, 1, 0, 2));
    put(enc_r(isa_pkg::FN_WWD, 2, 0, 0));
    expect_wwd(16'hD2E1);
    // loads at r0+0x10 and r0-0x10 and the sum stored at r0+0x20.
    sum = dmem[16'h0045] + dmem[16'h0025];
    put(enc_i(isa_pkg::OP_LWD, 0, 1, 8'h10));
    put(enc_i(isa_pkg::OP_LWD, 0, 2, 8'hF0));
    put(enc_r(isa_pkg::FN_ADD, 1, 2, 3));
    put(enc_i(isa_pkg::OP_SWD, 0, 3, 8'h20));
    exp_st[n_st] = {16'h0055, sum};
    n_st++;
    put(enc_i(isa_pkg::OP_LWD, 0, 1, 8'h20));
    put(enc_r(isa_pkg::FN_WWD, 1, 0, 0));
    expect_wwd(sum);
    // r3 negative, r1 equal to r0; wrong paths output r3 as marker.
    put(enc_r(isa_pkg::FN_TCP, 0, 0, 3));
    put(enc_i(isa_pkg::OP_ADI, 0, 1, 0));
    put(enc_i(isa_pkg::OP_BNE, 0, 3, 1));
    put(enc_r(isa_pkg::FN_WWD, 3, 0, 0));
    put(enc_i(isa_pkg::OP_BNE, 0, 1, 1));
    put(enc_r(isa_pkg::FN_WWD, 0, 0, 0));
    expect_wwd(16'h0035);
    put(enc_i(isa_pkg::OP_BEQ, 0, 1, 1));
    put(enc_r(isa_pkg::FN_WWD, 3, 0, 0));
    put(enc_i(isa_pkg::OP_BEQ, 0, 3, 1));
    put(enc_r(isa_pkg::FN_WWD, 0, 0, 0));
    expect_wwd(16'h0035);
    put(enc_i(isa_pkg::OP_BGZ, 0, 0, 1));
    put(enc_r(isa_pkg::FN_WWD, 3, 0, 0));
    put(enc_i(isa_pkg::OP_BGZ, 3, 0, 1));
    put(enc_r(isa_pkg::FN_WWD, 0, 0, 0));
    expect_wwd(16'h0035);
    put(enc_i(isa_pkg::OP_BLZ, 3, 0, 1));
    put(enc_r(isa_pkg::FN_WWD, 3, 0, 0));
    put(enc_i(isa_pkg::OP_BLZ, 0, 0, 1));
    put(enc_r(isa_pkg::FN_WWD, 0, 0, 0));
    expect_wwd(16'h0035);
    // jumps over one marker each.
    put(enc_j(isa_pkg::OP_JMP, prog_len + 2));
    put(enc_r(isa_pkg::FN_WWD, 3, 0, 0));
    q = prog_len;
    put(enc_j(isa_pkg::OP_JAL, q + 2));
    put(enc_r(isa_pkg::FN_WWD, 3, 0, 0));
    put(enc_r(isa_pkg::FN_WWD, 2, 0, 0));
    expect_wwd(16'(q + 1));
    put(enc_r(isa_pkg::FN_SUB, 0, 0, 1));
    put(enc_i(isa_pkg::OP_ADI, 1, 1, prog_len + 3));
    put(enc_r(isa_pkg::FN_JPR, 1, 0, 0));
    put(enc_r(isa_pkg::FN_WWD, 3, 0, 0));
    put(enc_i(isa_pkg::OP_ADI, 1, 1, 4));
    q = prog_len;
    put(enc_r(isa_pkg::FN_JRL, 1, 0, 0));
    put(enc_r(isa_pkg::FN_WWD, 3, 0, 0));
    put(enc_r(isa_pkg::FN_WWD, 3, 0, 0));
    put(enc_r(isa_pkg::FN_WWD, 2, 0, 0));
    expect_wwd(16'(q + 1));
    put(enc_r(isa_pkg::FN_HLT, 0, 0, 0));
endtask

`endif

/* dv/tb_cpu_core.sv */
`include "cpu_macros.svh"

module tb_cpu_core;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int IMEM_IDX_W   = 6;
    localparam int IMEM_WORDS   = 64;
    localparam int MAX_EXP      = 32;
    localparam int HALT_TIMEOUT = 500;
    localparam int HOLD_CYCLES  = 20;

    typedef struct packed {
        logic [`CPU_WORD_W-1:0] addr;
        logic [`CPU_WORD_W-1:0] data;
    } store_t;

    logic                   clk;
    logic                   arst_n;
    logic [`CPU_WORD_W-1:0] inst_addr;
    logic [`CPU_WORD_W-1:0] inst_data;
    logic [`CPU_WORD_W-1:0] d_addr;
    logic [`CPU_WORD_W-1:0] d_wdata;
    logic                   d_write;
    logic [`CPU_WORD_W-1:0] d_rdata;
    logic                   wwd_valid;
    logic [`CPU_WORD_W-1:0] wwd_data;
    logic                   halted;

    logic [`CPU_WORD_W-1:0] imem [IMEM_WORDS];
    logic [`CPU_WORD_W-1:0] dmem [1 << `CPU_WORD_W];
    logic [`CPU_WORD_W-1:0] exp_wwd [MAX_EXP];
    store_t                 exp_st [MAX_EXP];
    int                     prog_len   = 0;
    int                     n_wwd      = 0;
    int                     n_st       = 0;
    int                     wwd_count  = 0;
    int                     st_count   = 0;
    int                     run_cycles = 0;
    int                     errors     = 0;
    integer                 seed       = 32'hf628_00d3;

    `include "tb_program.svh"

    cpu_core i_cpu_core (
        .clk       (clk),
        .arst_n    (arst_n),
        .inst_addr (inst_addr),
        .inst_data (inst_data),
        .d_addr    (d_addr),
        .d_wdata   (d_wdata),
        .d_write   (d_write),
        .d_rdata   (d_rdata),
        .wwd_valid (wwd_valid),
        .wwd_data  (wwd_data),
        .halted    (halted)
    );

    always #2 clk = ~clk;

    ////////////////////
    // memory models
    ////////////////////

    assign inst_data = imem[inst_addr[IMEM_IDX_W-1:0]];
    assign d_rdata   = dmem[d_addr];

    always @(posedge clk) begin
        if (d_write) begin
            dmem[d_addr] <= d_wdata;
        end
    end

    // strobe and cycle counters.
    always @(posedge clk) begin
        if (arst_n) begin
            run_cycles <= run_cycles + 1;
            if (wwd_valid) begin
                wwd_count <= wwd_count + 1;
            end
            if (d_write) begin
                st_count <= st_count + 1;
            end
        end
    end

    ////////////////////
    // checks
    ////////////////////

    // reset and START cycle; pc still 0 on the first RUN cycle.
    reset_pc: assert property (@(posedge clk) (!arst_n || run_cycles <= 1) |-> inst_addr == '0)
        else begin
            errors++;
            $display("FAILED inst_addr: got %h expected %h", $sampled(inst_addr), 16'h0);
        end

    reset_strobes: assert property (@(posedge clk)
            (!arst_n || run_cycles == 0) |-> !d_write && !wwd_valid && !halted)
        else begin
            errors++;
            $display("strobe or halted was high during reset or the START cycle");
        end

    wwd_extra: assert property (@(posedge clk) disable iff (!arst_n)
            wwd_valid |-> wwd_count < n_wwd)
        else begin
            errors++;
            $display("WWD output beyond the end of the expected list");
        end

    wwd_value: assert property (@(posedge clk) disable iff (!arst_n)
            wwd_valid && wwd_count < n_wwd |-> wwd_data == exp_wwd[wwd_count])
        else begin
            errors++;
            $display("FAILED wwd_data: got %h expected %h",
                     $sampled(wwd_data), exp_wwd[$sampled(wwd_count)]);
        end

    store_extra: assert property (@(posedge clk) disable iff (!arst_n)
            d_write |-> st_count < n_st)
        else begin
            errors++;
            $display("data write beyond the end of the expected store list");
        end

    store_addr: assert property (@(posedge clk) disable iff (!arst_n)
            d_write && st_count < n_st |-> d_addr == exp_st[st_count].addr)
        else begin
            errors++;
            $display("FAILED d_addr: got %h expected %h",
                     $sampled(d_addr), exp_st[$sampled(st_count)].addr);
        end

    store_data: assert property (@(posedge clk) disable iff (!arst_n)
            d_write && st_count < n_st |-> d_wdata == exp_st[st_count].data)
        else begin
            errors++;
            $display("FAILED d_wdata: got %h expected %h",
                     $sampled(d_wdata), exp_st[$sampled(st_count)].data);
        end

    halt_quiet: assert property (@(posedge clk) disable iff (!arst_n)
            halted |-> !wwd_valid && !d_write)
        else begin
            errors++;
            $display("strobe seen after the core halted");
        end

    halt_pc: assert property (@(posedge clk) disable iff (!arst_n)
            halted && $past(halted) |-> $stable(inst_addr))
        else begin
            errors++;
            $display("FAILED inst_addr: got %h expected %h",
                     $sampled(inst_addr), $past(inst_addr));
        end

    ////////////////////
    // stimulus
    ////////////////////

    initial begin
        int wait_cycles;
        clk    = 1'b0;
        arst_n = 1'b0;
        for (int a = 0; a < (1 << `CPU_WORD_W); a++) begin
            dmem[a] = 16'($random(seed));
        end
        // unused slots halt, address kept in the register fields.
        for (int a = 0; a < IMEM_WORDS; a++) begin
            imem[a] = {isa_pkg::OP_RTYPE, 6'(a), isa_pkg::FN_HLT};
        end
        build_program();
        repeat (2) @(posedge clk);
        arst_n <= 1'b1;
        wait_cycles = 0;
        while (!halted && wait_cycles < HALT_TIMEOUT) begin
            @(posedge clk);
            wait_cycles++;
        end
        if (!halted) begin
            errors++;
            $display("timeout, halted did not rise within %0d cycles", HALT_TIMEOUT);
        end else begin
            // held slot now decodes as a store and later as a WWD.
            imem[inst_addr[IMEM_IDX_W-1:0]] <= enc_i(isa_pkg::OP_SWD, 0, 0, 0);
            for (int c = 0; c < HOLD_CYCLES; c++) begin
                @(posedge clk);
                if (c == HOLD_CYCLES / 2) begin
                    imem[inst_addr[IMEM_IDX_W-1:0]] <= enc_r(isa_pkg::FN_WWD, 0, 0, 0);
                end
            end
        end
        wwd_total: assert (wwd_count == n_wwd)
            else begin
                errors++;
                $display("FAILED wwd count: got %h expected %h", wwd_count, n_wwd);
            end
        store_total: assert (st_count == n_st)
            else begin
                errors++;
                $display("FAILED store count: got %h expected %h", st_count, n_st);
            end
        $display("error count: %0d", errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

/* list.f */
+incdir+hw
+incdir+dv
hw/isa_pkg.sv
hw/ctrl_pkg.sv
hw/control_unit.sv
hw/alu.sv
hw/register_file.sv
hw/pc_unit.sv
hw/cpu_core.sv
dv/tb_cpu_core.sv
